//--- hw/ctr_defines.svh
// Build-time sizing for the counter-block generator
// Slice geometry, intake buffer depth and output credit count

`ifndef CTR_DEFINES_SVH
`define CTR_DEFINES_SVH

////////////////////////////////////////
// Counter geometry
////////////////////////////////////////

// Bits handled per increment step
`define CTR_SLICE_W 16

// Slices per counter
// 8 slices of 16 bits give 128
`define CTR_NUM_SLICES 8

////////////////////////////////////////
// Flow control
////////////////////////////////////////

// Intake entries, also the upstream credits after reset
`define CTR_CMD_DEPTH 2

// Downstream credits after reset
`define CTR_OUT_CREDITS 2

`endif

//--- hw/ctr_pkg.sv
// Counter datapath types
// State encoding of the slice-serial increment FSM

`include "ctr_defines.svh"

package ctr_pkg;

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  // One slice, the unit of a single increment step
  typedef logic [`CTR_SLICE_W-1:0] ctr_slice_t;

  // Selects one slice of the counter
  typedef logic [$clog2(`CTR_NUM_SLICES)-1:0] ctr_slice_idx_t;

  // Whole counter value
  typedef logic [`CTR_SLICE_W*`CTR_NUM_SLICES-1:0] ctr_block_t;

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  // Counter FSM states
  // Every pair of codes differs in four bits
  // Single bit flips never land on another legal state
  typedef enum logic [5:0] {
    CTR_IDLE  = 6'b001011,
    CTR_INCR  = 6'b110001,
    CTR_ERROR = 6'b100110
  } ctr_state_e;

endpackage

//--- hw/ctr_io_pkg.sv
// Command and block formats at the generator boundary
// Command opcode encoding

package ctr_io_pkg;

  ////////////////////////////////////////
  // Upstream side
  ////////////////////////////////////////

  // What a command asks for
  typedef enum logic {
    CTR_OP_LOAD = 1'b0,
    CTR_OP_INCR = 1'b1
  } ctr_op_e;

  // Opcode plus initial value
  // iv only matters for a load
  typedef struct packed {
    ctr_op_e             op;
    ctr_pkg::ctr_block_t iv;
  } ctr_cmd_t;

  ////////////////////////////////////////
  // Downstream side
  ////////////////////////////////////////

  // Counter block stamped with its running number
  typedef struct packed {
    logic [31:0]         seq;
    ctr_pkg::ctr_block_t data;
  } ctr_blk_t;

endpackage

//--- hw/ctr_cmd_intake.sv
// Command intake FIFO with upstream credit return
// Pops LOADs and INCRs toward the counter register and FSM

`timescale 1ns/1ns

`include "ctr_defines.svh"

module ctr_cmd_intake (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 cmd_valid_i,
  input  ctr_io_pkg::ctr_cmd_t cmd_i,
  output logic                 cmd_credit_o,
  input  logic                 fsm_ready_i,
  input  logic                 out_empty_i,
  output logic                 load_en_o,
  output ctr_pkg::ctr_block_t  load_val_o,
  output logic                 incr_o
);
  import ctr_io_pkg::*;

  localparam int unsigned depth = `CTR_CMD_DEPTH;
  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned cnt_w = $clog2(depth + 1);

  ctr_cmd_t         mem_q [depth];
  logic [ptr_w-1:0] wr_ptr_q, rd_ptr_q;
  logic [cnt_w-1:0] count_q;
  logic             head_valid;
  ctr_cmd_t         head_cmd;
  logic             pop_load, pop_incr, pop;

  ////////////////////////////////////////
  // Head and pop decision
  ////////////////////////////////////////

  assign head_valid = (count_q != '0);
  assign head_cmd   = mem_q[rd_ptr_q];

  // Load only needs an idle FSM
  assign pop_load = head_valid && fsm_ready_i && (head_cmd.op == CTR_OP_LOAD);
  // Increment also needs room for the block it produces
  assign pop_incr = head_valid && fsm_ready_i && out_empty_i && (head_cmd.op == CTR_OP_INCR);
  assign pop      = pop_load || pop_incr;

  assign load_en_o    = pop_load;
  assign load_val_o   = head_cmd.iv;
  assign incr_o       = pop_incr;
  // One credit back per removed entry
  assign cmd_credit_o = pop;

  ////////////////////////////////////////
  // Storage and pointers
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (cmd_valid_i) begin
      mem_q[wr_ptr_q] <= cmd_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (cmd_valid_i) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + ptr_w'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + ptr_w'(1);
      end
      count_q <= count_q + cnt_w'(cmd_valid_i) - cnt_w'(pop);
    end
  end

  // Upstream must never outrun its credits
  a_no_write_when_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_valid_i |-> (count_q != cnt_w'(depth)))
    else $error("command written into a full intake buffer");

endmodule

//--- hw/ctr_fsm.sv
// Slice-serial counter increment FSM
// Carry chain across slices, terminal error state, sticky alert

`timescale 1ns/1ns

`include "ctr_defines.svh"

module ctr_fsm (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    incr_i,
  input  logic                    fault_i,
  output logic                    ready_o,
  output logic                    alert_o,
  output ctr_pkg::ctr_slice_idx_t slice_idx_o,
  input  ctr_pkg::ctr_slice_t     slice_i,
  output ctr_pkg::ctr_slice_t     slice_o,
  output logic                    slice_we_o,
  output logic                    done_o
);
  import ctr_pkg::*;

  ctr_state_e            state_d, state_q;
  ctr_slice_idx_t        idx_d, idx_q;
  logic                  carry_d, carry_q;
  logic                  done_d, done_q;
  logic                  alert_q;
  logic [`CTR_SLICE_W:0] sum;

  ////////////////////////////////////////
  // Slice adder
  ////////////////////////////////////////

  // Top bit is the carry into the next slice
  assign sum     = {1'b0, slice_i} + {{`CTR_SLICE_W{1'b0}}, carry_q};
  assign slice_o = sum[`CTR_SLICE_W-1:0];

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    idx_d      = idx_q;
    carry_d    = carry_q;
    ready_o    = 1'b0;
    slice_we_o = 1'b0;

    unique case (state_q)
      CTR_IDLE: begin
        // Hold off while the finished block is being captured
        ready_o = ~done_q;
        if (incr_i) begin
          // Start at the lowest slice with a carry-in of one
          idx_d   = '0;
          carry_d = 1'b1;
          state_d = CTR_INCR;
        end
      end

      CTR_INCR: begin
        slice_we_o = 1'b1;
        idx_d      = idx_q + ctr_slice_idx_t'(1);
        carry_d    = sum[`CTR_SLICE_W];
        if (idx_q == ctr_slice_idx_t'(`CTR_NUM_SLICES - 1)) begin
          state_d = CTR_IDLE;
        end
      end

      // Terminal, only reset leaves it
      CTR_ERROR: begin
        state_d = CTR_ERROR;
      end

      // Corrupted state register
      default: begin
        state_d = CTR_ERROR;
      end
    endcase

    // External fault overrides everything
    if (fault_i) begin
      state_d = CTR_ERROR;
    end
  end

  // Last slice written this cycle
  assign done_d = (state_q == CTR_INCR) && (state_d == CTR_IDLE);

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= CTR_IDLE;
      idx_q   <= '0;
      carry_q <= 1'b0;
      done_q  <= 1'b0;
      alert_q <= 1'b0;
    end else begin
      state_q <= state_d;
      idx_q   <= idx_d;
      carry_q <= carry_d;
      done_q  <= done_d;
      // Sticky, set together with entry into the error state
      alert_q <= alert_q | (state_d == CTR_ERROR);
    end
  end

  assign slice_idx_o = idx_q;
  assign done_o      = done_q;
  assign alert_o     = alert_q;

  // Any state outside the working pair must have raised the alert
  a_state_valid : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !alert_o |-> (state_q inside {CTR_IDLE, CTR_INCR}))
    else $error("counter FSM left its legal states without alert");

endmodule

//--- hw/ctr_reg.sv
// 128-bit counter register organised as slices
// Whole-value load, single-slice write and slice read port

`timescale 1ns/1ns

`include "ctr_defines.svh"

module ctr_reg (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    load_en_i,
  input  ctr_pkg::ctr_block_t     load_val_i,
  input  ctr_pkg::ctr_slice_idx_t slice_idx_i,
  input  logic                    slice_we_i,
  input  ctr_pkg::ctr_slice_t     slice_wdata_i,
  output ctr_pkg::ctr_slice_t     slice_rdata_o,
  output ctr_pkg::ctr_block_t     value_o
);
  import ctr_pkg::*;

  // Slice 0 holds the least significant bits
  ctr_slice_t slices_q [`CTR_NUM_SLICES];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `CTR_NUM_SLICES; i++) begin
        slices_q[i] <= '0;
      end
    end else if (load_en_i) begin
      // New initial value from a LOAD
      for (int i = 0; i < `CTR_NUM_SLICES; i++) begin
        slices_q[i] <= load_val_i[i*`CTR_SLICE_W +: `CTR_SLICE_W];
      end
    end else if (slice_we_i) begin
      slices_q[slice_idx_i] <= slice_wdata_i;
    end
  end

  // Read port feeding the FSM adder
  assign slice_rdata_o = slices_q[slice_idx_i];

  // Flattened value for the output stage
  always_comb begin
    for (int i = 0; i < `CTR_NUM_SLICES; i++) begin
      value_o[i*`CTR_SLICE_W +: `CTR_SLICE_W] = slices_q[i];
    end
  end

  // Intake only loads while the FSM is idle
  a_no_load_during_incr : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(load_en_i && slice_we_i))
    else $error("counter load collided with a slice write");

endmodule

//--- hw/ctr_out_stage.sv
// One-entry output holder for finished counter blocks
// Sequence stamping and downstream credit counting

`timescale 1ns/1ns

`include "ctr_defines.svh"

module ctr_out_stage (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 done_i,
  input  ctr_pkg::ctr_block_t  value_i,
  output logic                 empty_o,
  output logic                 blk_valid_o,
  output ctr_io_pkg::ctr_blk_t blk_o,
  input  logic                 blk_credit_i
);
  import ctr_io_pkg::*;

  localparam int unsigned credits = `CTR_OUT_CREDITS;
  localparam int unsigned cred_w  = $clog2(credits + 1);

  logic              full_q;
  logic [cred_w-1:0] credit_q;
  logic [31:0]       seq_q;
  ctr_blk_t          blk_q;
  logic              send;

  // Held block leaves as soon as a credit is there
  assign send        = full_q && (credit_q != '0);
  assign blk_valid_o = send;
  assign blk_o       = blk_q;
  assign empty_o     = ~full_q;

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q   <= 1'b0;
      credit_q <= cred_w'(credits);
      seq_q    <= '0;
    end else begin
      // Capture only arrives while empty
      full_q   <= done_i | (full_q & ~send);
      credit_q <= credit_q + cred_w'(blk_credit_i) - cred_w'(send);
      if (done_i) begin
        seq_q <= seq_q + 32'd1;
      end
    end
  end

  // Block payload
  always_ff @(posedge clk_i) begin
    if (done_i) begin
      blk_q.seq  <= seq_q;
      blk_q.data <= value_i;
    end
  end

  // Downstream may only return what it was given
  a_credit_bound : assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_q <= cred_w'(credits))
    else $error("downstream returned more credits than issued");

endmodule

//--- hw/ctr_gen_top.sv
// Counter-block generator top level
// Intake, counter FSM, counter register and output stage

`timescale 1ns/1ns

module ctr_gen_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 cmd_valid_i,
  input  ctr_io_pkg::ctr_cmd_t cmd_i,
  output logic                 cmd_credit_o,
  input  logic                 fault_i,
  output logic                 alert_o,
  output logic                 blk_valid_o,
  output ctr_io_pkg::ctr_blk_t blk_o,
  input  logic                 blk_credit_i
);
  import ctr_pkg::*;

  // Intake to processing
  logic           load_en, incr, fsm_ready, out_empty;
  ctr_block_t     load_val;
  // FSM and register
  ctr_slice_idx_t slice_idx;
  ctr_slice_t     slice_rdata, slice_wdata;
  logic           slice_we;
  // Processing to output side
  logic           blk_done;
  ctr_block_t     ctr_value;

  ctr_cmd_intake u_intake (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_i        (cmd_i),
    .cmd_credit_o (cmd_credit_o),
    .fsm_ready_i  (fsm_ready),
    .out_empty_i  (out_empty),
    .load_en_o    (load_en),
    .load_val_o   (load_val),
    .incr_o       (incr)
  );

  ctr_fsm u_fsm (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .incr_i      (incr),
    .fault_i     (fault_i),
    .ready_o     (fsm_ready),
    .alert_o     (alert_o),
    .slice_idx_o (slice_idx),
    .slice_i     (slice_rdata),
    .slice_o     (slice_wdata),
    .slice_we_o  (slice_we),
    .done_o      (blk_done)
  );

  ctr_reg u_reg (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .load_en_i     (load_en),
    .load_val_i    (load_val),
    .slice_idx_i   (slice_idx),
    .slice_we_i    (slice_we),
    .slice_wdata_i (slice_wdata),
    .slice_rdata_o (slice_rdata),
    .value_o       (ctr_value)
  );

  ctr_out_stage u_out (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .done_i       (blk_done),
    .value_i      (ctr_value),
    .empty_o      (out_empty),
    .blk_valid_o  (blk_valid_o),
    .blk_o        (blk_o),
    .blk_credit_i (blk_credit_i)
  );

endmodule

//--- bench/ctr_gen_tb.sv
// Random-stimulus testbench for the counter-block generator
// Reference counter model, credit bookkeeping on both sides, watchdog

`timescale 1ns/1ns

`include "ctr_defines.svh"

module ctr_gen_tb;
  import ctr_pkg::*;
  import ctr_io_pkg::*;

  localparam int n_random = 200;
  // Random stream plus directed, back-pressure, fault and post-reset commands
  localparam int n_cmds = n_random + 17;
  localparam int timeout_cycles = n_cmds * (`CTR_NUM_SLICES + 10) + 1000;

  logic     clk_i = 1'b0;
  logic     rst_ni;
  logic     cmd_valid_i = 1'b0;
  ctr_cmd_t cmd_i = '0;
  logic     cmd_credit_o;
  logic     fault_i;
  logic     alert_o;
  logic     blk_valid_o;
  ctr_blk_t blk_o;
  logic     blk_credit_i = 1'b0;

  // Commands waiting to go upstream, blocks the model expects
  ctr_cmd_t   cmd_q [$];
  ctr_blk_t   exp_q [$];
  ctr_block_t model_ctr;
  int         next_seq;
  int         up_credits;
  // Blocks received whose credit has not gone back yet
  int         owed = 0;
  int         errors = 0;
  int         cmds_sent = 0;
  int         blocks_seen = 0;
  int         credits_returned = 0;
  logic       hold_credits = 1'b0;
  logic       faulted = 1'b0;

  ctr_gen_top dut0 (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_i        (cmd_i),
    .cmd_credit_o (cmd_credit_o),
    .fault_i      (fault_i),
    .alert_o      (alert_o),
    .blk_valid_o  (blk_valid_o),
    .blk_o        (blk_o),
    .blk_credit_i (blk_credit_i)
  );

  always #20 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Upstream side
  ////////////////////////////////////////

  always @(negedge clk_i) begin : upstream
    ctr_cmd_t cmd;
    ctr_blk_t blk;
    cmd_valid_i = 1'b0;
    if (!rst_ni) begin
      up_credits = `CTR_CMD_DEPTH;
      model_ctr  = '0;
      next_seq   = 0;
    end else begin
      // Random gaps between commands
      if (cmd_q.size() != 0 && up_credits > 0 && $urandom_range(0, 3) != 0) begin
        cmd         = cmd_q.pop_front();
        cmd_i       = cmd;
        cmd_valid_i = 1'b1;
        up_credits--;
        cmds_sent++;
        if (cmd.op == CTR_OP_LOAD) begin
          model_ctr = cmd.iv;
        end else begin
          // Wraps modulo 2**128
          model_ctr = model_ctr + ctr_block_t'(1);
          blk.seq   = next_seq;
          blk.data  = model_ctr;
          exp_q.push_back(blk);
          next_seq++;
        end
      end
      // Pulse seen now, credit usable from the next cycle
      if (cmd_credit_o) begin
        credits_returned++;
        up_credits++;
        if (faulted) begin
          $display("Command credit returned after the fault at %0t ns", $time);
          errors++;
        end
        if (up_credits > `CTR_CMD_DEPTH) begin
          $display("More command credits returned than commands sent at %0t ns", $time);
          errors++;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Downstream side
  ////////////////////////////////////////

  always @(negedge clk_i) begin : downstream
    ctr_blk_t exp_blk;
    blk_credit_i = 1'b0;
    if (!rst_ni) begin
      owed = 0;
    end else begin
      if (blk_valid_o) begin
        blocks_seen++;
        owed++;
        if (faulted) begin
          $display("Block sent after the fault at %0t ns", $time);
          errors++;
        end else if (exp_q.size() == 0) begin
          $display("Block sent with no increment pending at %0t ns", $time);
          errors++;
        end else begin
          exp_blk = exp_q.pop_front();
          if (blk_o !== exp_blk) begin
            $display("FAILED at %0t ns: block seq %0d data %h, expected seq %0d data %h",
                     $time, blk_o.seq, blk_o.data, exp_blk.seq, exp_blk.data);
            errors++;
          end
        end
      end
      // Credit back after a random delay
      if (!hold_credits && owed > 0 && $urandom_range(0, 2) == 0) begin
        blk_credit_i = 1'b1;
        owed--;
      end
    end
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic queue_cmd(input ctr_op_e op, input ctr_block_t iv);
    ctr_cmd_t cmd;
    cmd.op = op;
    cmd.iv = iv;
    cmd_q.push_back(cmd);
  endtask

  // Mix of plain random values and carry-heavy patterns
  function automatic ctr_block_t rand_iv();
    ctr_block_t v;
    v = ctr_block_t'({$urandom, $urandom, $urandom, $urandom});
    case ($urandom_range(0, 3))
      0: v = '1;
      1: v[`CTR_SLICE_W*(`CTR_NUM_SLICES-1)-1:0] = '1;
      2: v[`CTR_SLICE_W-1:0] = '1;
      default: ;
    endcase
    return v;
  endfunction

  task automatic apply_reset();
    @(negedge clk_i);
    rst_ni  = 1'b0;
    fault_i = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    exp_q.delete();
    faulted = 1'b0;
    if (alert_o !== 1'b0) begin
      $display("FAILED at %0t ns: alert_o is %b during reset", $time, alert_o);
      errors++;
    end
    if (blk_valid_o !== 1'b0 || cmd_credit_o !== 1'b0) begin
      $display("FAILED at %0t ns: valid or credit high during reset", $time);
      errors++;
    end
    rst_ni = 1'b1;
  endtask

  // All commands consumed, all blocks seen, all credits home
  task automatic wait_idle();
    @(negedge clk_i);
    while (cmd_q.size() != 0 || exp_q.size() != 0 || owed != 0) begin
      @(negedge clk_i);
    end
    // A trailing load is popped within a cycle or two of an idle FSM
    repeat (4) @(negedge clk_i);
    if (up_credits != `CTR_CMD_DEPTH) begin
      $display("Command credits not all back while idle at %0t ns, %0d of %0d held",
               $time, up_credits, `CTR_CMD_DEPTH);
      errors++;
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin : main
    int blocks_before;
    int credits_before;
    rst_ni  = 1'b0;
    fault_i = 1'b0;
    void'($urandom(32'heda1));
    apply_reset();

    // Carry into the top slice, then a full wrap
    queue_cmd(CTR_OP_LOAD, {16'h1234, {(`CTR_SLICE_W*(`CTR_NUM_SLICES-1)){1'b1}}});
    queue_cmd(CTR_OP_INCR, '0);
    queue_cmd(CTR_OP_LOAD, '1);
    queue_cmd(CTR_OP_INCR, '0);
    queue_cmd(CTR_OP_INCR, '0);
    wait_idle();

    // Random stream, mostly increments
    for (int i = 0; i < n_random; i++) begin
      if ($urandom_range(0, 9) < 8) begin
        queue_cmd(CTR_OP_INCR, '0);
      end else begin
        queue_cmd(CTR_OP_LOAD, rand_iv());
      end
    end
    wait_idle();

    // Back-pressure with downstream credits withheld
    hold_credits  = 1'b1;
    blocks_before = blocks_seen;
    repeat (6) queue_cmd(CTR_OP_INCR, '0);
    repeat (120) @(negedge clk_i);
    if (blocks_seen - blocks_before > `CTR_OUT_CREDITS) begin
      $display("FAILED at %0t ns: %0d blocks sent without credits back",
               $time, blocks_seen - blocks_before);
      errors++;
    end
    // Output full, intake full, upstream out of credits
    if (up_credits != 0) begin
      $display("FAILED at %0t ns: upstream holds %0d credits under back-pressure",
               $time, up_credits);
      errors++;
    end
    hold_credits = 1'b0;
    wait_idle();

    // Fault in the middle of an increment
    credits_before = credits_returned;
    queue_cmd(CTR_OP_INCR, '0);
    while (credits_returned == credits_before) begin
      @(negedge clk_i);
    end
    repeat (2) @(negedge clk_i);
    fault_i = 1'b1;
    faulted = 1'b1;
    @(negedge clk_i);
    fault_i = 1'b0;
    // These stay buffered behind the dead FSM
    queue_cmd(CTR_OP_INCR, '0);
    queue_cmd(CTR_OP_INCR, '0);
    repeat (40) begin
      if (alert_o !== 1'b1) begin
        $display("FAILED at %0t ns: alert_o is %b after the fault", $time, alert_o);
        errors++;
      end
      @(negedge clk_i);
    end

    // Second reset, counting restarts from zero
    apply_reset();
    repeat (3) queue_cmd(CTR_OP_INCR, '0);
    wait_idle();

    $display("Run complete: %0d errors, %0d commands, %0d blocks",
             errors, cmds_sent, blocks_seen);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (timeout_cycles) @(posedge clk_i);
    $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
    $display(">>> FAIL");
    $finish;
  end

endmodule

//--- compile.f
+incdir+hw
hw/ctr_pkg.sv
hw/ctr_io_pkg.sv
hw/ctr_cmd_intake.sv
hw/ctr_fsm.sv
hw/ctr_reg.sv
hw/ctr_out_stage.sv
hw/ctr_gen_top.sv
bench/ctr_gen_tb.sv

//--- Makefile
# Verilator build, run and lint for the counter-block generator

TOP := ctr_gen_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): compile.f hw/*.sv hw/*.svh bench/*.sv
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir
